//--- design/pmu_pkg.sv
package pmu_pkg;

    // block, key and memory word share one width
    localparam int BLOCK_WIDTH = 32;
    localparam int ADDR_WIDTH  = 6;

    // header is opcode in the low bits, block count above it
    localparam int HDR_WIDTH = 16;
    localparam int LEN_WIDTH = 12;
    localparam int OP_WIDTH  = HDR_WIDTH - LEN_WIDTH;

    localparam int MEM_DEPTH = 2 ** ADDR_WIDTH;

    // any other opcode value is dropped by the command decoder
    typedef enum logic [OP_WIDTH-1:0] {
        OP_LOAD_KEY = 4'h1,
        OP_STREAM   = 4'h2,
        OP_PROGRAM  = 4'h3
    } pmu_opcode_e;

    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [BLOCK_WIDTH-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                   valid;
        logic [BLOCK_WIDTH-1:0] data;
    } block_t;

endpackage

//--- design/pmu_cmd_decoder.sv
`timescale 1ns/1ps

module pmu_cmd_decoder (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            data_i,
    input  logic                            data_valid_i,
    input  logic                            mem_gnt_i,
    output pmu_pkg::block_t                 stream_blk_o,
    output logic                            key_wr_o,
    output logic [pmu_pkg::BLOCK_WIDTH-1:0] key_data_o,
    output pmu_pkg::mem_req_t               mem_req_o,
    output logic                            busy_o
);

    localparam int CNT_WIDTH = $clog2(pmu_pkg::BLOCK_WIDTH);
    localparam int PAD_WIDTH = pmu_pkg::BLOCK_WIDTH - pmu_pkg::LEN_WIDTH;

    typedef enum logic [2:0] {
        S_HEADER,
        S_KEY,
        S_STREAM,
        S_PROGRAM,
        S_COUNT_WR
    } state_e;

    state_e                          state_q;
    logic [pmu_pkg::BLOCK_WIDTH-1:0] shift_q;
    logic [CNT_WIDTH-1:0]            bit_cnt_q;
    logic [pmu_pkg::LEN_WIDTH-1:0]   len_q;
    logic [pmu_pkg::LEN_WIDTH-1:0]   blk_cnt_q;
    logic [pmu_pkg::HDR_WIDTH-1:0]   hdr_word;
    logic [pmu_pkg::BLOCK_WIDTH-1:0] blk_word;
    logic [pmu_pkg::BLOCK_WIDTH-1:0] len_word;
    logic [pmu_pkg::LEN_WIDTH-1:0]   hdr_len;
    pmu_pkg::pmu_opcode_e            opcode;
    logic                            hdr_done;
    logic                            blk_done;
    logic                            last_blk;

    // bits arrive lsb first so the newest bit lands at the top
    assign blk_word = {data_i, shift_q[pmu_pkg::BLOCK_WIDTH-1:1]};
    assign hdr_word = {data_i, shift_q[pmu_pkg::BLOCK_WIDTH-1 -: pmu_pkg::HDR_WIDTH-1]};
    assign opcode   = pmu_pkg::pmu_opcode_e'(hdr_word[pmu_pkg::OP_WIDTH-1:0]);
    assign hdr_len  = hdr_word[pmu_pkg::HDR_WIDTH-1 -: pmu_pkg::LEN_WIDTH];
    assign len_word = {{PAD_WIDTH{1'b0}}, len_q};

    assign hdr_done = data_valid_i && (state_q == S_HEADER)
                      && (bit_cnt_q == CNT_WIDTH'(pmu_pkg::HDR_WIDTH - 1));
    assign blk_done = data_valid_i && (state_q inside {S_KEY, S_STREAM, S_PROGRAM})
                      && (bit_cnt_q == CNT_WIDTH'(pmu_pkg::BLOCK_WIDTH - 1));
    assign last_blk = (blk_cnt_q == len_q - 1'b1);

    // a partly received header also counts as busy
    assign busy_o = (state_q != S_HEADER) || (bit_cnt_q != '0);

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            state_q      <= S_HEADER;
            shift_q      <= '0;
            bit_cnt_q    <= '0;
            len_q        <= '0;
            blk_cnt_q    <= '0;
            stream_blk_o <= '0;
            key_wr_o     <= 1'b0;
            key_data_o   <= '0;
            mem_req_o    <= '0;
        end
        else
        begin
            stream_blk_o.valid <= 1'b0;
            key_wr_o           <= 1'b0;
            if (mem_gnt_i)
            begin
                mem_req_o.valid <= 1'b0;
            end

            if (data_valid_i)
            begin
                shift_q   <= blk_word;
                bit_cnt_q <= hdr_done ? '0 : bit_cnt_q + 1'b1;
            end

            case (state_q)
                S_HEADER:
                begin
                    if (hdr_done)
                    begin
                        len_q     <= hdr_len;
                        blk_cnt_q <= '0;
                        // unknown opcode stays here
                        if (hdr_len != '0)
                        begin
                            case (opcode)
                                pmu_pkg::OP_LOAD_KEY: state_q <= S_KEY;
                                pmu_pkg::OP_STREAM:   state_q <= S_STREAM;
                                pmu_pkg::OP_PROGRAM:  state_q <= S_PROGRAM;
                                default:              state_q <= S_HEADER;
                            endcase
                        end
                        else if (opcode == pmu_pkg::OP_PROGRAM)
                        begin
                            // empty image still records its length
                            state_q <= S_COUNT_WR;
                        end
                    end
                end
                S_COUNT_WR:
                begin
                    // image length goes to word 0
                    mem_req_o <= '{valid: 1'b1, write: 1'b1, addr: '0, wdata: len_word};
                    state_q   <= S_HEADER;
                end
                default:
                begin
                    if (blk_done)
                    begin
                        blk_cnt_q <= blk_cnt_q + 1'b1;
                        if (state_q == S_KEY)
                        begin
                            key_wr_o   <= 1'b1;
                            key_data_o <= blk_word;
                            state_q    <= S_HEADER;
                        end
                        else if (state_q == S_STREAM)
                        begin
                            stream_blk_o <= '{valid: 1'b1, data: blk_word};
                            if (last_blk)
                            begin
                                state_q <= S_HEADER;
                            end
                        end
                        else
                        begin
                            mem_req_o <= '{valid: 1'b1, write: 1'b1,
                                           addr: blk_cnt_q[pmu_pkg::ADDR_WIDTH-1:0] + 1'b1,
                                           wdata: blk_word};
                            if (last_blk)
                            begin
                                state_q <= S_COUNT_WR;
                            end
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- design/block_decoder.sv
`timescale 1ns/1ps

module block_decoder (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  pmu_pkg::block_t                 stream_blk_i,
    input  pmu_pkg::block_t                 boot_blk_i,
    input  logic                            key_wr_i,
    input  logic [pmu_pkg::BLOCK_WIDTH-1:0] key_data_i,
    output pmu_pkg::block_t                 dec_blk_o
);

    logic [pmu_pkg::BLOCK_WIDTH-1:0] key_q;
    pmu_pkg::block_t                 in_blk;
    pmu_pkg::block_t                 xor_q;

    // stream and boot blocks never arrive together
    assign in_blk = stream_blk_i.valid ? stream_blk_i : boot_blk_i;

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            key_q     <= '0;
            xor_q     <= '0;
            dec_blk_o <= '0;
        end
        else
        begin
            if (key_wr_i)
            begin
                key_q <= key_data_i;
            end
            xor_q.valid     <= in_blk.valid;
            xor_q.data      <= in_blk.data ^ key_q;
            // stage two swaps byte order
            dec_blk_o.valid <= xor_q.valid;
            dec_blk_o.data  <= {<<8{xor_q.data}};
        end
    end

endmodule

//--- design/nv_mem_arbiter.sv
`timescale 1ns/1ps

module nv_mem_arbiter (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  pmu_pkg::mem_req_t               cmd_req_i,
    input  pmu_pkg::mem_req_t               boot_req_i,
    input  logic [pmu_pkg::BLOCK_WIDTH-1:0] mem_rdata_i,
    output logic                            cmd_gnt_o,
    output logic                            boot_gnt_o,
    output pmu_pkg::mem_req_t               mem_req_o,
    output logic [pmu_pkg::BLOCK_WIDTH-1:0] boot_rdata_o,
    output logic                            boot_rvalid_o
);

    logic boot_rd_q;

    // command decoder always wins
    assign cmd_gnt_o  = cmd_req_i.valid;
    assign boot_gnt_o = boot_req_i.valid && !cmd_req_i.valid;
    assign mem_req_o  = cmd_req_i.valid ? cmd_req_i : boot_req_i;

    // memory read data shows up one cycle after the granted read
    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            boot_rd_q <= 1'b0;
        end
        else
        begin
            boot_rd_q <= boot_gnt_o && !boot_req_i.write;
        end
    end

    assign boot_rdata_o  = mem_rdata_i;
    assign boot_rvalid_o = boot_rd_q;

endmodule

//--- design/nv_memory.sv
`timescale 1ns/1ps

module nv_memory (
    input  logic                            clk,
    input  pmu_pkg::mem_req_t               mem_req_i,
    output logic [pmu_pkg::BLOCK_WIDTH-1:0] rdata_o
);

    // contents survive reset
    logic [pmu_pkg::BLOCK_WIDTH-1:0] mem_q [pmu_pkg::MEM_DEPTH];

    always_ff @(posedge clk)
    begin
        if (mem_req_i.valid)
        begin
            if (mem_req_i.write)
            begin
                mem_q[mem_req_i.addr] <= mem_req_i.wdata;
            end
            else
            begin
                rdata_o <= mem_q[mem_req_i.addr];
            end
        end
    end

endmodule

//--- design/boot_sequencer.sv
`timescale 1ns/1ps

module boot_sequencer (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            boot_i,
    input  logic                            idle_i,
    input  logic                            mem_gnt_i,
    input  logic [pmu_pkg::BLOCK_WIDTH-1:0] mem_rdata_i,
    input  logic                            mem_rvalid_i,
    input  logic                            scan_done_i,
    output pmu_pkg::mem_req_t               mem_req_o,
    output pmu_pkg::block_t                 boot_blk_o,
    output logic                            busy_o
);

    typedef enum logic [2:0] {
        B_IDLE,
        B_LEN,
        B_READ,
        B_WAIT_DATA,
        B_WAIT_SCAN
    } state_e;

    state_e                        state_q;
    logic [pmu_pkg::LEN_WIDTH-1:0] len_q;
    logic [pmu_pkg::LEN_WIDTH-1:0] idx_q;

    function automatic pmu_pkg::mem_req_t rd_req(input logic [pmu_pkg::LEN_WIDTH-1:0] idx);
        pmu_pkg::mem_req_t req;
        req       = '0;
        req.valid = 1'b1;
        req.addr  = idx[pmu_pkg::ADDR_WIDTH-1:0];
        return req;
    endfunction

    assign busy_o = (state_q != B_IDLE);

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            state_q    <= B_IDLE;
            len_q      <= '0;
            idx_q      <= '0;
            mem_req_o  <= '0;
            boot_blk_o <= '0;
        end
        else
        begin
            boot_blk_o.valid <= 1'b0;
            // request is held until the arbiter grants it
            if (mem_gnt_i)
            begin
                mem_req_o.valid <= 1'b0;
            end

            case (state_q)
                B_IDLE:
                begin
                    if (boot_i && idle_i)
                    begin
                        mem_req_o <= rd_req('0);
                        state_q   <= B_LEN;
                    end
                end
                B_LEN:
                begin
                    if (mem_rvalid_i)
                    begin
                        len_q <= mem_rdata_i[pmu_pkg::LEN_WIDTH-1:0];
                        idx_q <= 1;
                        if (mem_rdata_i[pmu_pkg::LEN_WIDTH-1:0] == '0)
                        begin
                            state_q <= B_IDLE;
                        end
                        else
                        begin
                            mem_req_o <= rd_req(1);
                            state_q   <= B_READ;
                        end
                    end
                end
                B_READ:
                begin
                    if (mem_gnt_i)
                    begin
                        state_q <= B_WAIT_DATA;
                    end
                end
                B_WAIT_DATA:
                begin
                    if (mem_rvalid_i)
                    begin
                        boot_blk_o <= '{valid: 1'b1, data: mem_rdata_i};
                        state_q    <= B_WAIT_SCAN;
                    end
                end
                B_WAIT_SCAN:
                begin
                    // next read only once the serializer is done
                    if (scan_done_i)
                    begin
                        if (idx_q == len_q)
                        begin
                            state_q <= B_IDLE;
                        end
                        else
                        begin
                            idx_q     <= idx_q + 1'b1;
                            mem_req_o <= rd_req(idx_q + 1'b1);
                            state_q   <= B_READ;
                        end
                    end
                end
                default:
                begin
                    state_q <= B_IDLE;
                end
            endcase
        end
    end

endmodule

//--- design/scan_serializer.sv
`timescale 1ns/1ps

module scan_serializer (
    input  logic            clk,
    input  logic            arst_n_i,
    input  pmu_pkg::block_t blk_i,
    output logic            scan_o,
    output logic            scan_valid_o,
    output logic            scan_done_o
);

    localparam int CNT_WIDTH = $clog2(pmu_pkg::BLOCK_WIDTH);

    logic [pmu_pkg::BLOCK_WIDTH-1:0] shift_q;
    logic [CNT_WIDTH-1:0]            cnt_q;
    logic                            active_q;
    logic                            last_bit;

    assign last_bit = active_q && (cnt_q == CNT_WIDTH'(pmu_pkg::BLOCK_WIDTH - 1));

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            shift_q  <= '0;
            cnt_q    <= '0;
            active_q <= 1'b0;
        end
        else if (blk_i.valid && (!active_q || last_bit))
        begin
            shift_q  <= blk_i.data;
            cnt_q    <= '0;
            active_q <= 1'b1;
        end
        else if (active_q)
        begin
            // lsb first
            shift_q  <= shift_q >> 1;
            cnt_q    <= cnt_q + 1'b1;
            active_q <= !last_bit;
        end
    end

    assign scan_o       = shift_q[0];
    assign scan_valid_o = active_q;
    assign scan_done_o  = last_bit;

endmodule

//--- design/pmu_top.sv
`timescale 1ns/1ps

module pmu_top (
    input  logic clk,
    input  logic arst_n_i,
    input  logic data_i,
    input  logic data_valid_i,
    input  logic boot_i,
    output logic scan_o,
    output logic scan_valid_o,
    output logic busy_o
);

    pmu_pkg::block_t                 stream_blk;
    pmu_pkg::block_t                 boot_blk;
    pmu_pkg::block_t                 dec_blk;
    pmu_pkg::mem_req_t               cmd_req;
    pmu_pkg::mem_req_t               boot_req;
    pmu_pkg::mem_req_t               mem_req;
    logic                            key_wr;
    logic [pmu_pkg::BLOCK_WIDTH-1:0] key_data;
    logic [pmu_pkg::BLOCK_WIDTH-1:0] mem_rdata;
    logic [pmu_pkg::BLOCK_WIDTH-1:0] boot_rdata;
    logic                            boot_rvalid;
    logic                            cmd_gnt;
    logic                            boot_gnt;
    logic                            cmd_busy;
    logic                            boot_busy;
    logic                            scan_done;

    assign busy_o = cmd_busy | boot_busy;

    pmu_cmd_decoder u_cmd_decoder (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .data_i       (data_i),
        .data_valid_i (data_valid_i),
        .mem_gnt_i    (cmd_gnt),
        .stream_blk_o (stream_blk),
        .key_wr_o     (key_wr),
        .key_data_o   (key_data),
        .mem_req_o    (cmd_req),
        .busy_o       (cmd_busy)
    );

    boot_sequencer u_boot_sequencer (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .boot_i       (boot_i),
        .idle_i       (!cmd_busy),
        .mem_gnt_i    (boot_gnt),
        .mem_rdata_i  (boot_rdata),
        .mem_rvalid_i (boot_rvalid),
        .scan_done_i  (scan_done),
        .mem_req_o    (boot_req),
        .boot_blk_o   (boot_blk),
        .busy_o       (boot_busy)
    );

    nv_mem_arbiter u_arbiter (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .cmd_req_i     (cmd_req),
        .boot_req_i    (boot_req),
        .mem_rdata_i   (mem_rdata),
        .cmd_gnt_o     (cmd_gnt),
        .boot_gnt_o    (boot_gnt),
        .mem_req_o     (mem_req),
        .boot_rdata_o  (boot_rdata),
        .boot_rvalid_o (boot_rvalid)
    );

    nv_memory u_nv_memory (
        .clk       (clk),
        .mem_req_i (mem_req),
        .rdata_o   (mem_rdata)
    );

    block_decoder u_block_decoder (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .stream_blk_i (stream_blk),
        .boot_blk_i   (boot_blk),
        .key_wr_i     (key_wr),
        .key_data_i   (key_data),
        .dec_blk_o    (dec_blk)
    );

    scan_serializer u_scan_serializer (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .blk_i        (dec_blk),
        .scan_o       (scan_o),
        .scan_valid_o (scan_valid_o),
        .scan_done_o  (scan_done)
    );

endmodule

//--- tests/pmu_tb.sv
`timescale 1ns/1ps

module pmu_tb;

    localparam int BW = pmu_pkg::BLOCK_WIDTH;
    // 7 headers and 15 blocks over all tests
    localparam int TOTAL_BITS = 7 * pmu_pkg::HDR_WIDTH + 15 * BW;
    localparam int CYCLE_LIMIT = 4 * TOTAL_BITS + 2000;

    logic clk;
    logic arst_n_i;
    logic data_i;
    logic data_valid_i;
    logic boot_i;
    logic scan_o;
    logic scan_valid_o;
    logic busy_o;

    logic          exp_q[$];
    logic          exp_head;
    int            exp_count;
    int            cycle_cnt = 0;
    bit            use_gaps;
    int unsigned   seed_val;
    logic [BW-1:0] key_val;
    logic [BW-1:0] image[$];

    pmu_top dut_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .data_i       (data_i),
        .data_valid_i (data_valid_i),
        .boot_i       (boot_i),
        .scan_o       (scan_o),
        .scan_valid_o (scan_valid_o),
        .busy_o       (busy_o)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    function automatic void sync_head();
        exp_count = exp_q.size();
        exp_head  = (exp_count != 0) ? exp_q[0] : 1'b0;
    endfunction

    // keyed xor then byte order reversed
    function automatic logic [BW-1:0] expected_word(input logic [BW-1:0] blk);
        logic [BW-1:0] x;
        logic [BW-1:0] r;
        x = blk ^ key_val;
        for (int i = 0; i < BW / 8; i++)
        begin
            r[8*i +: 8] = x[8*(BW/8-1-i) +: 8];
        end
        return r;
    endfunction

    function automatic void push_expected(input logic [BW-1:0] blk);
        logic [BW-1:0] w;
        w = expected_word(blk);
        for (int i = 0; i < BW; i++)
        begin
            exp_q.push_back(w[i]);
        end
        sync_head();
    endfunction

    task automatic send_bit(input logic b);
        int gap;
        gap = use_gaps ? $urandom_range(3, 0) : 0;
        repeat (gap)
        begin
            @(posedge clk);
            data_valid_i <= 1'b0;
        end
        @(posedge clk);
        data_i       <= b;
        data_valid_i <= 1'b1;
    endtask

    task automatic send_header(input logic [3:0] op, input logic [11:0] len);
        logic [15:0] hdr;
        hdr = {len, op};
        for (int i = 0; i < 16; i++)
        begin
            send_bit(hdr[i]);
        end
    endtask

    task automatic send_block(input logic [BW-1:0] blk);
        for (int i = 0; i < BW; i++)
        begin
            send_bit(blk[i]);
        end
    endtask

    task automatic settle();
        @(posedge clk);
        data_valid_i <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    // waits for a quiet window before checking that every expected bit is gone
    task automatic drain();
        int quiet;
        quiet = 0;
        while (quiet < 40)
        begin
            @(posedge clk);
            quiet = (scan_valid_o || busy_o) ? 0 : quiet + 1;
        end
        assert (exp_count == 0)
            else abort_run($sformatf("%0d expected scan bits never appeared", exp_count));
    endtask

    task automatic boot();
        while (busy_o)
        begin
            @(posedge clk);
        end
        foreach (image[i])
        begin
            push_expected(image[i]);
        end
        @(posedge clk);
        boot_i <= 1'b1;
        @(posedge clk);
        boot_i <= 1'b0;
        @(negedge clk);
        assert (busy_o) else abort_run("busy_o did not rise after the boot strobe");
    endtask

    // expected bits are popped on the edge that follows each checked bit
    always @(posedge clk)
    begin
        if (arst_n_i && scan_valid_o && exp_q.size() != 0)
        begin
            void'(exp_q.pop_front());
            sync_head();
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            abort_run("timeout: cycle limit reached before the tests completed");
        end
    end

    assert property (@(negedge clk) disable iff (!arst_n_i) scan_valid_o |-> exp_count != 0)
        else abort_run($sformatf("scan bit appeared at %0t with none expected", $time));

    assert property (@(negedge clk) disable iff (!arst_n_i)
                     (scan_valid_o && exp_count != 0) |-> scan_o == exp_head)
        else abort_run($sformatf("ERR %0t scan_o expected %0b received %0b",
                                 $time, exp_head, scan_o));

    initial
    begin
        clk          = 1'b0;
        arst_n_i     = 1'b0;
        data_i       = 1'b0;
        data_valid_i = 1'b0;
        boot_i       = 1'b0;
        use_gaps     = 1'b0;
        seed_val     = $urandom(32);
        sync_head();
        repeat (8) @(posedge clk);
        arst_n_i <= 1'b1;
        repeat (2) @(negedge clk);
        assert (!scan_valid_o && !busy_o) else abort_run("outputs not idle after reset");
        repeat (20) @(posedge clk);

        // key load followed by 3 contiguous stream blocks
        key_val = $urandom();
        send_header(pmu_pkg::OP_LOAD_KEY, 12'd1);
        send_block(key_val);
        send_header(pmu_pkg::OP_STREAM, 12'd3);
        repeat (3)
        begin
            logic [BW-1:0] blk;
            blk = $urandom();
            push_expected(blk);
            send_block(blk);
        end
        settle();
        drain();

        // gaps between serial bits
        use_gaps = 1'b1;
        send_header(pmu_pkg::OP_STREAM, 12'd4);
        repeat (4)
        begin
            logic [BW-1:0] blk;
            blk = $urandom();
            push_expected(blk);
            send_block(blk);
        end
        use_gaps = 1'b0;
        settle();
        drain();

        // unknown opcode is dropped and the next header is taken
        send_header(4'hA, 12'd2);
        send_header(pmu_pkg::OP_STREAM, 12'd2);
        repeat (2)
        begin
            logic [BW-1:0] blk;
            blk = $urandom();
            push_expected(blk);
            send_block(blk);
        end
        settle();
        drain();

        // program an image and replay it
        send_header(pmu_pkg::OP_PROGRAM, 12'd5);
        repeat (5)
        begin
            logic [BW-1:0] blk;
            blk = $urandom();
            image.push_back(blk);
            send_block(blk);
        end
        settle();
        boot();
        drain();

        // zero count stores an empty image
        image.delete();
        send_header(pmu_pkg::OP_PROGRAM, 12'd0);
        settle();
        boot();
        drain();

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- compile.f
design/pmu_pkg.sv
design/pmu_cmd_decoder.sv
design/block_decoder.sv
design/nv_mem_arbiter.sv
design/nv_memory.sv
design/boot_sequencer.sv
design/scan_serializer.sv
design/pmu_top.sv
tests/pmu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module pmu_tb -f compile.f -o pmu_sim
./obj_dir/pmu_sim
